/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_qpu_exu
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

/* rtl/qpu_exu.sv */
//////////////////////////////////////////////////
// qpu execution stage top
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module qpu_exu (
  input  logic                        clk,
  input  logic                        i_reset,
  // instruction input
  input  logic                        i_valid,
  output logic                        o_ready,
  input  logic [31:0]                 i_ir,
  // time queue write
  output logic                        o_tiq_valid,
  input  logic                        i_tiq_ready,
  output logic [`QPU_TIME_WIDTH-1:0]  o_tiq_data,
  // retirement
  output logic                        o_cmt_valid,
  output logic [`QPU_RFIDX_WIDTH-1:0] o_cmt_rdidx,
  output logic [`QPU_XLEN-1:0]        o_cmt_data
);

  // register file reads
  logic [`QPU_RFIDX_WIDTH-1:0] rs1idx;
  logic [`QPU_RFIDX_WIDTH-1:0] rs2idx;
  logic [`QPU_XLEN-1:0]        rs1;
  logic [`QPU_XLEN-1:0]        rs2;

  // register file write
  logic                        rf_wen;
  logic [`QPU_RFIDX_WIDTH-1:0] rf_wdx;
  logic [`QPU_XLEN-1:0]        rf_wdata;

  // alu to write-back
  logic                        alu_valid;
  logic                        alu_wait;
  logic [`QPU_RFIDX_WIDTH-1:0] alu_rd;
  logic                        alu_rdwen;
  logic [`QPU_XLEN-1:0]        alu_result;

  // scoreboard, stall and time
  logic [`QPU_RFIDX_WIDTH-1:0] alu_busy_rd;
  logic                        alu_busy_wen;
  logic [`QPU_RFIDX_WIDTH-1:0] wb_busy_rd;
  logic                        wb_busy_wen;
  logic                        stall;
  logic [`QPU_TIME_WIDTH-1:0]  cur_time;

  qpu_exu_stage_if u_stage_if ();

  qpu_exu_regfile u_regfile (
    .clk      (clk),
    .i_rs1idx (rs1idx),
    .i_rs2idx (rs2idx),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .i_wen    (rf_wen),
    .i_wdx    (rf_wdx),
    .i_wdata  (rf_wdata)
  );

  qpu_exu_decode u_decode (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_ir           (i_ir),
    .o_rs1idx       (rs1idx),
    .o_rs2idx       (rs2idx),
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .i_stall        (stall),
    .i_alu_busy_rd  (alu_busy_rd),
    .i_alu_busy_wen (alu_busy_wen),
    .i_wb_busy_rd   (wb_busy_rd),
    .i_wb_busy_wen  (wb_busy_wen),
    .o_iss          (u_stage_if.issue)
  );

  qpu_exu_alu u_alu (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_stall    (stall),
    .i_iss      (u_stage_if.exec),
    .i_time     (cur_time),
    .o_valid    (alu_valid),
    .o_wait     (alu_wait),
    .o_rd       (alu_rd),
    .o_rdwen    (alu_rdwen),
    .o_result   (alu_result),
    .o_busy_rd  (alu_busy_rd),
    .o_busy_wen (alu_busy_wen)
  );

  qpu_exu_wbck u_wbck (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (alu_valid),
    .i_wait      (alu_wait),
    .i_rd        (alu_rd),
    .i_rdwen     (alu_rdwen),
    .i_result    (alu_result),
    .o_stall     (stall),
    .o_time      (cur_time),
    .o_rf_wen    (rf_wen),
    .o_rf_wdx    (rf_wdx),
    .o_rf_wdata  (rf_wdata),
    .o_tiq_valid (o_tiq_valid),
    .i_tiq_ready (i_tiq_ready),
    .o_tiq_data  (o_tiq_data),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt_rdidx (o_cmt_rdidx),
    .o_cmt_data  (o_cmt_data),
    .o_busy_rd   (wb_busy_rd),
    .o_busy_wen  (wb_busy_wen)
  );

endmodule

`default_nettype wire

/* rtl/qpu_exu_alu.sv */
//////////////////////////////////////////////////
// execute stage
// arithmetic, logic and next time point
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module qpu_exu_alu import qpu_exu_pkg::*; (
  input  logic                        clk,
  input  logic                        i_reset,
  input  logic                        i_stall,
  qpu_exu_stage_if.exec               i_iss,
  // time as seen by the next wait
  input  logic [`QPU_TIME_WIDTH-1:0]  i_time,
  // to write-back
  output logic                        o_valid,
  output logic                        o_wait,
  output logic [`QPU_RFIDX_WIDTH-1:0] o_rd,
  output logic                        o_rdwen,
  output logic [`QPU_XLEN-1:0]        o_result,
  // to scoreboard
  output logic [`QPU_RFIDX_WIDTH-1:0] o_busy_rd,
  output logic                        o_busy_wen
);

  logic [`QPU_XLEN-1:0]       alu_res;
  logic [`QPU_TIME_WIDTH-1:0] time_nxt;

  // old time plus imm plus rs1, wraps at the time width
  assign time_nxt = i_time + i_iss.opa[`QPU_TIME_WIDTH-1:0] +
                    i_iss.opb[`QPU_TIME_WIDTH-1:0];

  always_comb begin
    case (i_iss.op)
      ALU_SUB:  alu_res = i_iss.opa - i_iss.opb;
      ALU_AND:  alu_res = i_iss.opa & i_iss.opb;
      ALU_OR:   alu_res = i_iss.opa | i_iss.opb;
      ALU_WAIT: alu_res = {{(`QPU_XLEN-`QPU_TIME_WIDTH){1'b0}}, time_nxt};
      default:  alu_res = i_iss.opa + i_iss.opb;
    endcase
  end

  //////////////////////////////////////////////////
  // result register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_iss.valid;
    end
  end

  // payload held with the valid
  always_ff @(posedge clk) begin
    if (!i_stall) begin
      o_wait   <= (i_iss.op == ALU_WAIT);
      o_rd     <= i_iss.rd;
      o_rdwen  <= i_iss.rdwen;
      o_result <= alu_res;
    end
  end

  // dest still being computed
  assign o_busy_rd  = o_rd;
  assign o_busy_wen = o_valid && o_rdwen;

endmodule

`default_nettype wire

/* rtl/qpu_exu_cfg.svh */
//////////////////////////////////////////////////
// qpu execution stage configuration
// widths, register count and opcode values
//////////////////////////////////////////////////
`ifndef QPU_EXU_CFG_SVH
`define QPU_EXU_CFG_SVH

// datapath and register file
`define QPU_XLEN         32
`define QPU_RF_NUM       16
`define QPU_RFIDX_WIDTH  4

// time register
`define QPU_TIME_WIDTH   24

// opcodes, anything else is a nop
`define QPU_OPC_ADD      4'h1
`define QPU_OPC_SUB      4'h2
`define QPU_OPC_AND      4'h3
`define QPU_OPC_OR       4'h4
`define QPU_OPC_ADDI     4'h5
`define QPU_OPC_WAIT     4'h6

`endif

/* rtl/qpu_exu_decode.sv */
//////////////////////////////////////////////////
// decode and issue stage
// operand read, scoreboard stall, input handshake
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module qpu_exu_decode import qpu_exu_pkg::*; (
  input  logic                        clk,
  input  logic                        i_reset,
  // instruction input
  input  logic                        i_valid,
  output logic                        o_ready,
  input  logic [31:0]                 i_ir,
  // register file reads
  output logic [`QPU_RFIDX_WIDTH-1:0] o_rs1idx,
  output logic [`QPU_RFIDX_WIDTH-1:0] o_rs2idx,
  input  logic [`QPU_XLEN-1:0]        i_rs1,
  input  logic [`QPU_XLEN-1:0]        i_rs2,
  // hold from write-back
  input  logic                        i_stall,
  // in-flight destinations
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_alu_busy_rd,
  input  logic                        i_alu_busy_wen,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_wb_busy_rd,
  input  logic                        i_wb_busy_wen,
  qpu_exu_stage_if.issue              o_iss
);

  instr_u               ir;
  logic [3:0]           opc;
  logic                 is_rtype;
  logic                 is_addi;
  logic                 is_wait;
  logic                 wr_reg;
  alu_op_e              dec_op;
  logic [`QPU_XLEN-1:0] imm_ext;
  logic                 hzd_rs1;
  logic                 hzd_rs2;
  logic                 accept;

  //////////////////////////////////////////////////
  // field decode
  assign ir       = i_ir;
  assign opc      = ir.r.opcode;
  assign o_rs1idx = ir.r.rs1;
  // only meaningful for the register format
  assign o_rs2idx = ir.r.rs2;

  assign is_rtype = (opc == `QPU_OPC_ADD) || (opc == `QPU_OPC_SUB) ||
                    (opc == `QPU_OPC_AND) || (opc == `QPU_OPC_OR);
  assign is_addi  = (opc == `QPU_OPC_ADDI);
  assign is_wait  = (opc == `QPU_OPC_WAIT);
  // x0 writes are dropped here, nothing downstream sees them
  assign wr_reg   = (is_rtype || is_addi) && (ir.r.rd != '0);

  // imm zero extended
  assign imm_ext  = {{(`QPU_XLEN-$bits(ir.i.imm)){1'b0}}, ir.i.imm};

  always_comb begin
    case (opc)
      `QPU_OPC_SUB:  dec_op = ALU_SUB;
      `QPU_OPC_AND:  dec_op = ALU_AND;
      `QPU_OPC_OR:   dec_op = ALU_OR;
      `QPU_OPC_WAIT: dec_op = ALU_WAIT;
      // add, addi and nops
      default:       dec_op = ALU_ADD;
    endcase
  end

  //////////////////////////////////////////////////
  // scoreboard against the three stages ahead
  assign hzd_rs1 = (is_rtype || is_addi || is_wait) && (
      (o_iss.valid && o_iss.rdwen && (o_iss.rd == o_rs1idx)) ||
      (i_alu_busy_wen && (i_alu_busy_rd == o_rs1idx)) ||
      (i_wb_busy_wen && (i_wb_busy_rd == o_rs1idx)));

  assign hzd_rs2 = is_rtype && (
      (o_iss.valid && o_iss.rdwen && (o_iss.rd == o_rs2idx)) ||
      (i_alu_busy_wen && (i_alu_busy_rd == o_rs2idx)) ||
      (i_wb_busy_wen && (i_wb_busy_rd == o_rs2idx)));

  assign o_ready = !i_stall && !hzd_rs1 && !hzd_rs2;
  assign accept  = i_valid && o_ready;

  //////////////////////////////////////////////////
  // issue register, frozen while stalled
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_iss.valid <= 1'b0;
    end else if (!i_stall) begin
      o_iss.valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_iss.op    <= dec_op;
      o_iss.rd    <= ir.r.rd;
      o_iss.rdwen <= wr_reg;
      o_iss.opa   <= i_rs1;
      o_iss.opb   <= is_rtype ? i_rs2 : imm_ext;
    end
  end

  // a pending time push must not lose the op waiting behind it
  a_hold_on_stall : assert property (@(posedge clk) disable iff (i_reset)
    (i_stall && o_iss.valid) |=> (o_iss.valid && $stable(o_iss.opa)));

endmodule

`default_nettype wire

/* rtl/qpu_exu_pkg.sv */
//////////////////////////////////////////////////
// qpu execution stage types
// instruction formats and alu operation codes
//////////////////////////////////////////////////
`default_nettype none

`include "qpu_exu_cfg.svh"

package qpu_exu_pkg;

  // register format, two sources
  typedef struct packed {
    logic [3:0]                      opcode;
    logic [`QPU_RFIDX_WIDTH-1:0]     rd;
    logic [`QPU_RFIDX_WIDTH-1:0]     rs1;
    logic [`QPU_RFIDX_WIDTH-1:0]     rs2;
    logic [27-3*`QPU_RFIDX_WIDTH:0]  pad;
  } instr_r_t;

  // immediate format, imm takes the rs2 slot and the padding
  typedef struct packed {
    logic [3:0]                      opcode;
    logic [`QPU_RFIDX_WIDTH-1:0]     rd;
    logic [`QPU_RFIDX_WIDTH-1:0]     rs1;
    logic [27-2*`QPU_RFIDX_WIDTH:0]  imm;
  } instr_i_t;

  // one word, read in either format by opcode
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_WAIT
  } alu_op_e;

endpackage

`default_nettype wire

/* rtl/qpu_exu_regfile.sv */
//////////////////////////////////////////////////
// classical register file, 2 read 1 write
// entry zero is tied to zero
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module qpu_exu_regfile (
  input  logic                        clk,
  // read ports
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs1idx,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs2idx,
  output logic [`QPU_XLEN-1:0]        o_rs1,
  output logic [`QPU_XLEN-1:0]        o_rs2,
  // write port from write-back
  input  logic                        i_wen,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_wdx,
  input  logic [`QPU_XLEN-1:0]        i_wdata
);

  logic [`QPU_XLEN-1:0] rf_q [`QPU_RF_NUM];

  // one flop row per entry
  for (genvar i = 0; i < `QPU_RF_NUM; i++) begin : g_rf
    if (i == 0) begin : g_zero
      // x0 reads zero whatever is written
      assign rf_q[i] = '0;
    end else begin : g_ent
      always_ff @(posedge clk) begin
        if (i_wen && (i_wdx == i)) begin
          rf_q[i] <= i_wdata;
        end
      end
    end
  end

  // combinational reads
  assign o_rs1 = rf_q[i_rs1idx];
  assign o_rs2 = rf_q[i_rs2idx];

  // decode drops rdwen for rd of zero, so write-back never targets x0
  a_no_x0_write : assert property (@(posedge clk)
    i_wen |-> (i_wdx != '0));

endmodule

`default_nettype wire

/* rtl/qpu_exu_stage_if.sv */
//////////////////////////////////////////////////
// decode to execute link
// carries one issued operation with its operands
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

interface qpu_exu_stage_if import qpu_exu_pkg::*; ();

  // op sitting between decode and alu
  logic                         valid;
  alu_op_e                      op;
  logic [`QPU_RFIDX_WIDTH-1:0]  rd;
  logic                         rdwen;

  // opa is always rs1, opb is rs2 or the immediate
  logic [`QPU_XLEN-1:0]         opa;
  logic [`QPU_XLEN-1:0]         opb;

  // decode side
  modport issue (output valid, op, rd, rdwen, opa, opb);

  // alu side
  modport exec (input valid, op, rd, rdwen, opa, opb);

endinterface

`default_nettype wire

/* rtl/qpu_exu_wbck.sv */
//////////////////////////////////////////////////
// write-back stage
// time register, register writes, time queue push
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module qpu_exu_wbck (
  input  logic                        clk,
  input  logic                        i_reset,
  // from alu
  input  logic                        i_valid,
  input  logic                        i_wait,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rd,
  input  logic                        i_rdwen,
  input  logic [`QPU_XLEN-1:0]        i_result,
  // pipeline hold and time to the alu
  output logic                        o_stall,
  output logic [`QPU_TIME_WIDTH-1:0]  o_time,
  // register file write
  output logic                        o_rf_wen,
  output logic [`QPU_RFIDX_WIDTH-1:0] o_rf_wdx,
  output logic [`QPU_XLEN-1:0]        o_rf_wdata,
  // time queue
  output logic                        o_tiq_valid,
  input  logic                        i_tiq_ready,
  output logic [`QPU_TIME_WIDTH-1:0]  o_tiq_data,
  // retirement
  output logic                        o_cmt_valid,
  output logic [`QPU_RFIDX_WIDTH-1:0] o_cmt_rdidx,
  output logic [`QPU_XLEN-1:0]        o_cmt_data,
  // to scoreboard
  output logic [`QPU_RFIDX_WIDTH-1:0] o_busy_rd,
  output logic                        o_busy_wen
);

  logic                        valid_q;
  logic                        wait_q;
  logic                        rdwen_q;
  logic [`QPU_RFIDX_WIDTH-1:0] rd_q;
  logic [`QPU_XLEN-1:0]        result_q;
  logic [`QPU_TIME_WIDTH-1:0]  time_q;

  //////////////////////////////////////////////////
  // stage register and time register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      time_q  <= '0;
    end else if (!o_stall) begin
      valid_q <= i_valid;
      if (i_valid && i_wait) begin
        time_q <= i_result[`QPU_TIME_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!o_stall) begin
      wait_q   <= i_wait;
      rdwen_q  <= i_rdwen;
      rd_q     <= i_rd;
      result_q <= i_result;
    end
  end

  // a wait in the alu loads time_q on the next move, so hand its value forward
  assign o_time = (i_valid && i_wait) ? i_result[`QPU_TIME_WIDTH-1:0] : time_q;

  // pending push is a wait held here
  assign o_tiq_valid = valid_q && wait_q;
  assign o_tiq_data  = time_q;
  assign o_stall     = o_tiq_valid && !i_tiq_ready;

  // register write and retirement pulse together
  assign o_rf_wen    = valid_q && rdwen_q;
  assign o_rf_wdx    = rd_q;
  assign o_rf_wdata  = result_q;
  assign o_cmt_valid = o_rf_wen;
  assign o_cmt_rdidx = rd_q;
  assign o_cmt_data  = result_q;

  assign o_busy_rd   = rd_q;
  assign o_busy_wen  = o_rf_wen;

  // queue data held until taken
  a_tiq_hold : assert property (@(posedge clk) disable iff (i_reset)
    (o_tiq_valid && !i_tiq_ready) |=> (o_tiq_valid && $stable(o_tiq_data)));

endmodule

`default_nettype wire

/* verification/tb_qpu_exu.sv */
//////////////////////////////////////////////////
// qpu execution stage testbench
// reference model, random stimulus, assertions
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qpu_exu_cfg.svh"

module tb_qpu_exu import qpu_exu_pkg::*; ();

  // load, random, chain, wait, mixed, x0 sections
  localparam int NUM_INSTR  = 15 + 40 + 20 + 16 + 60 + 3;
  localparam int TIMEOUT_NS = (NUM_INSTR * 20 + 10) * 10;

  logic                        clk = 1'b0;
  logic                        i_reset;
  logic                        i_valid;
  logic                        o_ready;
  logic [31:0]                 i_ir;
  logic                        o_tiq_valid;
  logic                        i_tiq_ready;
  logic [`QPU_TIME_WIDTH-1:0]  o_tiq_data;
  logic                        o_cmt_valid;
  logic [`QPU_RFIDX_WIDTH-1:0] o_cmt_rdidx;
  logic [`QPU_XLEN-1:0]        o_cmt_data;

  // model state and expected outputs
  logic [`QPU_XLEN-1:0]        model_rf [`QPU_RF_NUM];
  logic [`QPU_TIME_WIDTH-1:0]  model_time;
  logic [`QPU_RFIDX_WIDTH-1:0] exp_rd_q [$];
  logic [`QPU_XLEN-1:0]        exp_data_q [$];
  logic [`QPU_TIME_WIDTH-1:0]  exp_time_q [$];
  logic [`QPU_RFIDX_WIDTH-1:0] exp_rd;
  logic [`QPU_XLEN-1:0]        exp_data;
  int                          err_mismatch = 0;
  int                          err_protocol = 0;
  logic                        rand_ready = 1'b0;

  always #5 clk = ~clk;

  qpu_exu UUT (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_ir        (i_ir),
    .o_tiq_valid (o_tiq_valid),
    .i_tiq_ready (i_tiq_ready),
    .o_tiq_data  (o_tiq_data),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt_rdidx (o_cmt_rdidx),
    .o_cmt_data  (o_cmt_data)
  );

  //////////////////////////////////////////////////
  // instruction builders
  function automatic logic [31:0] make_r(input logic [3:0] opc, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2);
    instr_u w;
    w.r.opcode = opc;
    w.r.rd     = rd;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    w.r.pad    = '0;
    return w;
  endfunction

  function automatic logic [31:0] make_i(input logic [3:0] opc, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [19:0] imm);
    instr_u w;
    w.i.opcode = opc;
    w.i.rd     = rd;
    w.i.rs1    = rs1;
    w.i.imm    = imm;
    return w;
  endfunction

  // apply one accepted instruction in program order
  task automatic model_accept(input logic [31:0] ir);
    instr_u               w;
    logic [`QPU_XLEN-1:0] a;
    logic [`QPU_XLEN-1:0] b;
    logic [`QPU_XLEN-1:0] res;
    logic                 wr;
    w   = ir;
    a   = model_rf[w.r.rs1];
    b   = model_rf[w.r.rs2];
    wr  = 1'b1;
    res = '0;
    case (w.r.opcode)
      `QPU_OPC_ADD:  res = a + b;
      `QPU_OPC_SUB:  res = a - b;
      `QPU_OPC_AND:  res = a & b;
      `QPU_OPC_OR:   res = a | b;
      `QPU_OPC_ADDI: res = a + {12'b0, w.i.imm};
      `QPU_OPC_WAIT: begin
        model_time = model_time + a[`QPU_TIME_WIDTH-1:0] + {4'b0, w.i.imm};
        exp_time_q.push_back(model_time);
        wr = 1'b0;
      end
      default:       wr = 1'b0;
    endcase
    // x0 stays zero and never retires
    if (wr && (w.r.rd != '0)) begin
      model_rf[w.r.rd] = res;
      exp_rd_q.push_back(w.r.rd);
      exp_data_q.push_back(res);
    end
  endtask

  // hold the word until taken, then drop valid
  task automatic issue_instr(input logic [31:0] ir);
    i_valid = 1'b1;
    i_ir    = ir;
    @(negedge clk);
    while (!o_ready) @(negedge clk);
    model_accept(ir);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  task automatic issue_random(input logic allow_wait);
    logic [3:0]  opc;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [19:0] imm;
    opc = 4'($urandom_range(5, 1));
    if (allow_wait && ($urandom_range(2, 0) == 0)) opc = `QPU_OPC_WAIT;
    // occasional nop
    if ($urandom_range(15, 0) == 0) opc = 4'h0;
    rd  = 4'($urandom_range(15, 0));
    rs1 = 4'($urandom_range(15, 0));
    rs2 = 4'($urandom_range(15, 0));
    imm = 20'($urandom);
    if ((opc == `QPU_OPC_ADDI) || (opc == `QPU_OPC_WAIT)) begin
      issue_instr(make_i(opc, rd, rs1, imm));
    end else begin
      issue_instr(make_r(opc, rd, rs1, rs2));
    end
  endtask

  //////////////////////////////////////////////////
  // time queue ready, random or always high
  always @(posedge clk) begin
    #1;
    i_tiq_ready = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
  end

  // retirement checker, sampled mid cycle
  always @(negedge clk) begin
    if (!i_reset && o_cmt_valid) begin
      if (exp_rd_q.size() == 0) begin
        err_protocol++;
        $display("retirement of register %0d seen with no instruction pending", o_cmt_rdidx);
      end else begin
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (o_cmt_rdidx == exp_rd) else begin
          err_mismatch++;
          $display("Mismatch o_cmt_rdidx: got %h expected %h", o_cmt_rdidx, exp_rd);
        end
        assert (o_cmt_data == exp_data) else begin
          err_mismatch++;
          $display("Mismatch o_cmt_data: got %h expected %h", o_cmt_data, exp_data);
        end
      end
    end
  end

  // time push checker, pop only when taken
  always @(negedge clk) begin
    if (!i_reset && o_tiq_valid) begin
      if (exp_time_q.size() == 0) begin
        err_protocol++;
        $display("time queue push seen with no wait instruction pending");
      end else begin
        assert (o_tiq_data == exp_time_q[0]) else begin
          err_mismatch++;
          $display("Mismatch o_tiq_data: got %h expected %h", o_tiq_data, exp_time_q[0]);
        end
        if (i_tiq_ready) void'(exp_time_q.pop_front());
      end
    end
  end

  // push held stable while the queue is full
  a_tiq_stable : assert property (@(posedge clk) disable iff (i_reset)
    (o_tiq_valid && !i_tiq_ready) |=> (o_tiq_valid && $stable(o_tiq_data)))
    else begin
      err_protocol++;
      $display("time queue push changed or dropped while the queue was not ready");
    end

  // no issue while the push waits
  a_ready_low : assert property (@(posedge clk) disable iff (i_reset)
    (o_tiq_valid && !i_tiq_ready) |-> !o_ready)
    else begin
      err_protocol++;
      $display("instruction input was ready while a time push was waiting");
    end

  //////////////////////////////////////////////////
  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns with results still pending", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

  // main sequence
  initial begin
    logic [3:0] prev;
    logic [3:0] prev2;
    logic [3:0] rd;
    void'($urandom(32'h998));
    i_reset     = 1'b1;
    i_valid     = 1'b0;
    i_ir        = '0;
    i_tiq_ready = 1'b1;
    model_time  = '0;
    for (int i = 0; i < `QPU_RF_NUM; i++) model_rf[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    i_reset = 1'b0;

    // nothing pending out of reset
    @(negedge clk);
    assert (!o_tiq_valid && !o_cmt_valid) else begin
      err_protocol++;
      $display("time push or retirement active right after reset");
    end
    @(posedge clk);
    #1;

    // load x1..x15 from x0
    for (int i = 1; i < `QPU_RF_NUM; i++) begin
      issue_instr(make_i(`QPU_OPC_ADDI, 4'(i), 4'h0, 20'($urandom)));
    end

    // random register and immediate ops
    repeat (40) issue_random(1'b0);

    // dependent chain, each op reads the one before
    prev  = 4'h1;
    prev2 = 4'h2;
    for (int k = 0; k < 20; k++) begin
      rd = 4'(k % 15 + 1);
      case (k % 4)
        0:       issue_instr(make_i(`QPU_OPC_ADDI, rd, prev, 20'(k + 3)));
        1:       issue_instr(make_r(`QPU_OPC_ADD, rd, prev, prev2));
        2:       issue_instr(make_r(`QPU_OPC_SUB, rd, prev, prev2));
        default: issue_instr(make_r(`QPU_OPC_OR, rd, prev2, prev));
      endcase
      prev2 = prev;
      prev  = rd;
    end

    // wait sequence with the queue always ready
    repeat (16) begin
      issue_instr(make_i(`QPU_OPC_WAIT, 4'h0, 4'($urandom_range(15, 0)), 20'($urandom)));
    end

    // mixed traffic under random back-pressure
    rand_ready = 1'b1;
    repeat (60) issue_random(1'b1);
    rand_ready = 1'b0;

    // x0 ignores writes and reads back zero
    issue_instr(make_i(`QPU_OPC_ADDI, 4'h0, 4'h3, 20'h5));
    issue_instr(make_r(`QPU_OPC_ADD, 4'h7, 4'h0, 4'h0));
    issue_instr(make_r(`QPU_OPC_OR, 4'h8, 4'h0, 4'h2));

    // drain, then look for stray outputs
    while ((exp_rd_q.size() != 0) || (exp_time_q.size() != 0)) @(negedge clk);
    repeat (10) @(negedge clk);

    $display("error counts: mismatch %0d, protocol %0d", err_mismatch, err_protocol);
    if ((err_mismatch == 0) && (err_protocol == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/qpu_exu_pkg.sv
rtl/qpu_exu_stage_if.sv
rtl/qpu_exu_regfile.sv
rtl/qpu_exu_decode.sv
rtl/qpu_exu_alu.sv
rtl/qpu_exu_wbck.sv
rtl/qpu_exu.sv
verification/tb_qpu_exu.sv
